// File: rtl/mem_access_pkg.sv
package mem_access_pkg;

  // cpu side and bus side share one 32-bit view of memory
  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] word_t;  // one data word
  typedef logic [3:0]  be_t;    // one enable per byte lane

  // access size as given by the load/store unit
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_t;  // 2'd3 is not a legal size

  // upper half of the address map is i/o, never cached
  localparam int UNCACHED_BIT = 31;

endpackage

// File: rtl/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

  // line geometry, 64 byte lines
  localparam int LINE_WORDS    = 16;
  localparam int NUM_BANKS     = 4;   // words interleaved over the banks
  localparam int BYTE_OFF_BITS = 6;   // log2 of line size in bytes

  typedef logic [$clog2(LINE_WORDS)-1:0] word_off_t;  // word within a line
  typedef logic [$clog2(NUM_BANKS)-1:0]  bank_sel_t;  // low bits of word_off_t

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,         // wait for a cpu request
    HIT_RESP,     // bank read done, write hit merged here
    WRITEBACK,    // dirty victim out, 16 beats
    REFILL,       // new line in, 16 beats
    REFILL_DONE,  // one bubble so the banks see the last beat
    UNC_ACCESS,   // single beat to i/o
    UNC_RESP      // answer the cpu for uncached access
  } ctrl_state_e;

endpackage

// File: rtl/data_bank.sv
`timescale 1ns/1ps

module data_bank #(
  parameter  int INDEX_BITS = 6,
  localparam int DEPTH      =
    (dcache_cfg_pkg::LINE_WORDS / dcache_cfg_pkg::NUM_BANKS) << INDEX_BITS,
  localparam int AW         = $clog2(DEPTH)
) (
  input  logic                  clk,
  input  logic [AW-1:0]         addr_i,   // line index then word row
  input  logic                  we_i,
  input  mem_access_pkg::be_t   be_i,
  input  mem_access_pkg::word_t wdata_i,
  output mem_access_pkg::word_t rdata_o
);
  import mem_access_pkg::*;

  word_t mem_q [DEPTH];

  always_ff @(posedge clk) begin
    // byte lane writes
    for (int b = 0; b < $bits(be_t); b++) begin
      if (we_i && be_i[b])
        mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
    end
    rdata_o <= mem_q[addr_i];  // old data on a same-address write
  end

endmodule

// File: rtl/tag_store.sv
`timescale 1ns/1ps

module tag_store #(
  parameter  int INDEX_BITS = 6,
  localparam int TAG_BITS   =
    $bits(mem_access_pkg::addr_t) - dcache_cfg_pkg::BYTE_OFF_BITS - INDEX_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [INDEX_BITS-1:0] index_i,
  input  logic [TAG_BITS-1:0]   tag_i,
  input  logic                  we_i,
  input  logic                  dirty_i,
  output logic                  hit_o,
  output logic                  dirty_o,
  output logic [TAG_BITS-1:0]   tag_o
);

  localparam int LINES = 1 << INDEX_BITS;

  logic [LINES-1:0]    valid_q;
  logic [LINES-1:0]    dirty_q;
  logic [TAG_BITS-1:0] tag_q [LINES];

  // a write always leaves the line valid
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
      tag_q   <= '{default: '0};
    end else if (we_i) begin
      valid_q[index_i] <= 1'b1;
      dirty_q[index_i] <= dirty_i;
      tag_q[index_i]   <= tag_i;
    end
  end

  // lookup is combinational, same cycle as the index
  assign tag_o   = tag_q[index_i];
  assign dirty_o = dirty_q[index_i];  // only ever set on a valid line
  assign hit_o   = valid_q[index_i] && (tag_q[index_i] == tag_i);

endmodule

// File: rtl/load_align.sv
`timescale 1ns/1ps

module load_align (
  input  mem_access_pkg::word_t     bank_rdata_i [dcache_cfg_pkg::NUM_BANKS],
  input  dcache_cfg_pkg::word_off_t word_i,       // request word or writeback beat
  input  logic [1:0]                addr_lo_i,
  input  mem_access_pkg::size_t     size_i,
  input  logic                      uncached_i,
  input  mem_access_pkg::word_t     unc_rdata_i,
  output mem_access_pkg::word_t     rdata_o,
  output mem_access_pkg::word_t     evict_word_o
);
  import mem_access_pkg::*;
  import dcache_cfg_pkg::*;

  bank_sel_t bank;
  word_t     bank_word;
  word_t     unc_word;

  // words interleave over banks by the low word bits
  assign bank      = word_i[$bits(bank_sel_t)-1:0];
  assign bank_word = bank_rdata_i[bank];

  // uncached loads come back zero extended
  always_comb begin
    case (size_i)
      SIZE_BYTE: unc_word = {24'h0, unc_rdata_i[{addr_lo_i, 3'b000} +: 8]};
      SIZE_HALF: unc_word = {16'h0, unc_rdata_i[{addr_lo_i[1], 4'b0000} +: 16]};
      SIZE_WORD: unc_word = unc_rdata_i;
      default:   unc_word = '0;  // illegal size reads as zero
    endcase
  end

  assign evict_word_o = bank_word;
  assign rdata_o      = uncached_i ? unc_word : bank_word;  // cached hits return full word

endmodule

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
  parameter  int INDEX_BITS = 6,
  localparam int TAG_BITS   = 32 - dcache_cfg_pkg::BYTE_OFF_BITS - INDEX_BITS
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 req_valid_i,
  input  logic                                 req_we_i,
  input  mem_access_pkg::addr_t                req_addr_i,
  input  mem_access_pkg::word_t                req_wdata_i,
  input  mem_access_pkg::be_t                  req_be_i,
  input  mem_access_pkg::size_t                req_size_i,
  input  logic                                 hit_i,
  input  logic                                 dirty_i,
  input  logic [TAG_BITS-1:0]                  old_tag_i,
  input  mem_access_pkg::word_t                evict_word_i,
  input  logic                                 wb_ack_i,
  input  mem_access_pkg::word_t                wb_dat_i,
  output logic                                 tag_we_o,
  output logic                                 tag_dirty_o,
  output logic [INDEX_BITS+1:0]                bank_addr_o,
  output logic [dcache_cfg_pkg::NUM_BANKS-1:0] bank_we_o,
  output mem_access_pkg::be_t                  bank_be_o,
  output mem_access_pkg::word_t                bank_wdata_o,
  output dcache_cfg_pkg::word_off_t            beat_o,
  output logic                                 uncached_o,
  output mem_access_pkg::word_t                unc_rdata_o,
  output logic                                 ready_o,
  output logic                                 wb_cyc_o,
  output logic                                 wb_stb_o,
  output logic                                 wb_we_o,
  output mem_access_pkg::addr_t                wb_adr_o,
  output mem_access_pkg::word_t                wb_dat_o,
  output mem_access_pkg::be_t                  wb_sel_o
);
  import mem_access_pkg::*;
  import dcache_cfg_pkg::*;

  ctrl_state_e           state_q;
  ctrl_state_e           state_d;
  word_off_t             beat_q;      // beat of the running burst
  word_off_t             beat_nxt;
  word_off_t             req_word;    // word of the cpu request
  logic [1:0]            row;         // word row inside a bank
  bank_sel_t             wr_bank;
  logic                  bank_wr;
  logic                  cached;
  logic                  last_beat;
  logic                  bus_active;
  logic                  ready_q;
  logic [INDEX_BITS-1:0] index;
  word_t                 unc_rdata_q;
  be_t                   unc_rd_sel;

  assign cached    = ~req_addr_i[UNCACHED_BIT];
  assign index     = req_addr_i[BYTE_OFF_BITS +: INDEX_BITS];
  assign req_word  = req_addr_i[2 +: $bits(word_off_t)];
  assign beat_nxt  = beat_q + word_off_t'(wb_ack_i);  // address moves after the ack
  assign last_beat = wb_ack_i && (beat_q == word_off_t'(LINE_WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // ready_q high means the cpu still shows the finished request
        if (req_valid_i && !ready_q) begin
          if (!cached)
            state_d = UNC_ACCESS;
          else if (hit_i)
            state_d = HIT_RESP;
          else if (dirty_i)
            state_d = WRITEBACK;  // victim out first
          else
            state_d = REFILL;
        end
      end
      HIT_RESP:    state_d = IDLE;
      WRITEBACK:   state_d = last_beat ? REFILL : WRITEBACK;
      REFILL:      state_d = last_beat ? REFILL_DONE : REFILL;
      REFILL_DONE: state_d = HIT_RESP;  // finish as a normal hit
      UNC_ACCESS:  state_d = wb_ack_i ? UNC_RESP : UNC_ACCESS;
      UNC_RESP:    state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      beat_q  <= '0;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      beat_q  <= (state_q == WRITEBACK || state_q == REFILL) ? beat_nxt : '0;
      ready_q <= (state_q == HIT_RESP) || (state_q == UNC_RESP);  // one cycle pulse
    end
  end

  // single uncached read word
  always_ff @(posedge clk) begin
    if (state_q == UNC_ACCESS && wb_ack_i)
      unc_rdata_q <= wb_dat_i;
  end

  // bank row, banks answer one cycle late
  always_comb begin
    case (state_q)
      IDLE:      row = hit_i ? req_word[3:2] : 2'b00;  // a miss may start a writeback
      WRITEBACK: row = beat_nxt[3:2];                  // prefetch word of next beat
      REFILL:    row = beat_q[3:2];
      default:   row = req_word[3:2];
    endcase
  end

  assign bank_addr_o  = {index, row};
  assign wr_bank      = (state_q == REFILL) ? beat_q[1:0] : req_word[1:0];
  assign bank_wr      = (state_q == REFILL && wb_ack_i) || (state_q == HIT_RESP && req_we_i);
  assign bank_we_o    = bank_wr ? (NUM_BANKS'(1) << wr_bank) : '0;
  assign bank_be_o    = (state_q == HIT_RESP) ? req_be_i : '1;  // refill writes full words
  assign bank_wdata_o = (state_q == REFILL) ? wb_dat_i : req_wdata_i;
  assign beat_o       = (state_q == WRITEBACK) ? beat_q : req_word;

  // write hit marks dirty, last refill beat installs a clean line
  assign tag_we_o    = (state_q == HIT_RESP && req_we_i) || (state_q == REFILL && last_beat);
  assign tag_dirty_o = (state_q == HIT_RESP);

  // lane select for an uncached read
  always_comb begin
    case (req_size_i)
      SIZE_BYTE: unc_rd_sel = be_t'(1) << req_addr_i[1:0];
      SIZE_HALF: unc_rd_sel = req_addr_i[1] ? 4'b1100 : 4'b0011;
      default:   unc_rd_sel = '1;
    endcase
  end

  assign bus_active = (state_q == WRITEBACK) || (state_q == REFILL) ||
                      (state_q == UNC_ACCESS);
  assign wb_cyc_o   = bus_active;
  assign wb_stb_o   = bus_active;
  assign wb_we_o    = (state_q == WRITEBACK) || (state_q == UNC_ACCESS && req_we_i);
  assign wb_dat_o   = (state_q == WRITEBACK) ? evict_word_i : req_wdata_i;
  assign wb_sel_o   = (state_q != UNC_ACCESS) ? '1 : (req_we_i ? req_be_i : unc_rd_sel);

  always_comb begin
    case (state_q)
      WRITEBACK: wb_adr_o = {old_tag_i, index, beat_q, 2'b00};  // victim address
      REFILL:    wb_adr_o = {req_addr_i[31:BYTE_OFF_BITS], beat_q, 2'b00};
      default:   wb_adr_o = {req_addr_i[31:2], 2'b00};
    endcase
  end

  assign uncached_o  = ~cached;
  assign unc_rdata_o = unc_rdata_q;
  assign ready_o     = ready_q;

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
  parameter int INDEX_BITS = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  // cpu request, held until ready_o
  input  logic                   req_valid_i,
  input  logic                   req_we_i,
  input  mem_access_pkg::addr_t  req_addr_i,
  input  mem_access_pkg::word_t  req_wdata_i,
  input  mem_access_pkg::be_t    req_be_i,
  input  mem_access_pkg::size_t  req_size_i,
  output logic                   ready_o,
  output mem_access_pkg::word_t  rdata_o,
  // wishbone classic master
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output mem_access_pkg::addr_t  wb_adr_o,
  output mem_access_pkg::word_t  wb_dat_o,
  output mem_access_pkg::be_t    wb_sel_o,
  input  mem_access_pkg::word_t  wb_dat_i,
  input  logic                   wb_ack_i
);
  import mem_access_pkg::*;
  import dcache_cfg_pkg::*;

  localparam int TAG_BITS = $bits(addr_t) - BYTE_OFF_BITS - INDEX_BITS;

  logic [INDEX_BITS-1:0] index;
  logic [TAG_BITS-1:0]   req_tag;
  logic [TAG_BITS-1:0]   old_tag;   // tag of the line sitting at index
  logic                  tag_we;
  logic                  tag_dirty;
  logic                  hit;
  logic                  line_dirty;

  logic [INDEX_BITS+1:0] bank_addr;  // index plus word row
  logic [NUM_BANKS-1:0]  bank_we;
  be_t                   bank_be;
  word_t                 bank_wdata;
  word_t                 bank_rdata [NUM_BANKS];

  word_off_t             beat;       // word steering into load_align
  logic                  uncached;
  word_t                 unc_rdata;
  word_t                 evict_word;

  assign index   = req_addr_i[BYTE_OFF_BITS +: INDEX_BITS];
  assign req_tag = req_addr_i[$bits(addr_t)-1 -: TAG_BITS];

  dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .req_we_i     (req_we_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i),
    .req_size_i   (req_size_i),
    .hit_i        (hit),
    .dirty_i      (line_dirty),
    .old_tag_i    (old_tag),
    .evict_word_i (evict_word),
    .wb_ack_i     (wb_ack_i),
    .wb_dat_i     (wb_dat_i),
    .tag_we_o     (tag_we),
    .tag_dirty_o  (tag_dirty),
    .bank_addr_o  (bank_addr),
    .bank_we_o    (bank_we),
    .bank_be_o    (bank_be),
    .bank_wdata_o (bank_wdata),
    .beat_o       (beat),
    .uncached_o   (uncached),
    .unc_rdata_o  (unc_rdata),
    .ready_o      (ready_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_o     (wb_dat_o),
    .wb_sel_o     (wb_sel_o)
  );

  tag_store #(.INDEX_BITS(INDEX_BITS)) u_tags (
    .clk     (clk),
    .rst     (rst),
    .index_i (index),
    .tag_i   (req_tag),
    .we_i    (tag_we),
    .dirty_i (tag_dirty),
    .hit_o   (hit),
    .dirty_o (line_dirty),
    .tag_o   (old_tag)
  );

  // all banks share address and data, only the write enable differs
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    data_bank #(.INDEX_BITS(INDEX_BITS)) u_bank (
      .clk     (clk),
      .addr_i  (bank_addr),
      .we_i    (bank_we[g]),
      .be_i    (bank_be),
      .wdata_i (bank_wdata),
      .rdata_o (bank_rdata[g])
    );
  end

  load_align u_align (
    .bank_rdata_i (bank_rdata),
    .word_i       (beat),
    .addr_lo_i    (req_addr_i[1:0]),
    .size_i       (req_size_i),
    .uncached_i   (uncached),
    .unc_rdata_i  (unc_rdata),
    .rdata_o      (rdata_o),
    .evict_word_o (evict_word)
  );

endmodule

// File: sim/dcache_properties.sv
`timescale 1ns/1ps

module dcache_properties (
  input logic                  clk,
  input logic                  rst,
  input logic                  wb_cyc_o,
  input logic                  wb_stb_o,
  input logic                  wb_we_o,
  input mem_access_pkg::addr_t wb_adr_o,
  input logic                  wb_ack_i,
  input logic                  ready_o
);
  import dcache_cfg_pkg::*;

  int fail_cnt = 0;  // failed assertions so far

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
    wb_stb_o |-> wb_cyc_o)
    else begin
      fail_cnt++;
      $error("stb high outside a bus cycle");
    end

  // classic master holds the request until ack
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o) && $stable(wb_we_o))
    else begin
      fail_cnt++;
      $error("address or write enable changed before ack");
    end

  a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    ready_o |=> !ready_o)
    else begin
      fail_cnt++;
      $error("ready held for two cycles");
    end

  // last beat of a writeback may hand over to the refill line
  a_burst_line: assert property (@(posedge clk) disable iff (rst)
    wb_stb_o && !(wb_ack_i && wb_adr_o[5:2] == 4'hf) |=>
      !wb_stb_o || wb_adr_o[31:BYTE_OFF_BITS] == $past(wb_adr_o[31:BYTE_OFF_BITS]))
    else begin
      fail_cnt++;
      $error("burst left its line");
    end

endmodule

bind dcache_ctrl dcache_properties u_props (.*);

// File: sim/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
  import mem_access_pkg::*;

  localparam int MAX_PAT = 64;
  localparam int COLS    = 6;    // op, addr, wdata, be, size, expected

  logic  clk = 1'b0;
  logic  rst;
  logic  req_valid;
  logic  req_we;
  addr_t req_addr;
  word_t req_wdata;
  be_t   req_be;
  size_t req_size;
  logic  ready;
  word_t rdata;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  addr_t wb_adr;
  word_t wb_dat_m;   // master write data
  be_t   wb_sel;
  word_t wb_dat;     // slave read data
  logic  wb_ack;

  word_t       pat [MAX_PAT*COLS];
  int          npat;
  logic        started = 1'b0;
  int          data_errs = 0;
  int          addr_errs = 0;
  int          be_errs = 0;
  int          other_errs = 0;
  word_t       shadow [addr_t];   // bus memory, word keyed
  logic [31:0] rng = 32'd69161;
  int          wait_left = 0;
  logic        ack_nxt;
  word_t       dat_nxt;
  word_t       cur;
  addr_t       bus_adr [$];        // beats of the current access
  logic        bus_we [$];
  be_t         bus_sel [$];
  logic        valid_m [64];       // expected tag state per line
  logic        dirty_m [64];
  logic [19:0] tag_m [64];

  dcache_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_be_i    (req_be),
    .req_size_i  (req_size),
    .ready_o     (ready),
    .rdata_o     (rdata),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_we_o     (wb_we),
    .wb_adr_o    (wb_adr),
    .wb_dat_o    (wb_dat_m),
    .wb_sel_o    (wb_sel),
    .wb_dat_i    (wb_dat),
    .wb_ack_i    (wb_ack)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // word w holds w[15:0] over its inverse
  function automatic word_t init_word(input addr_t a);
    logic [15:0] w;
    w = a[17:2];
    return {w, ~w};
  endfunction

  function automatic word_t mem_read(input addr_t a);
    return shadow.exists(a) ? shadow[a] : init_word(a);
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      data_errs++;
      $display("Error %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      addr_errs++;
      $display("Error %s bus address: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input be_t exp, input be_t act);
    if (act !== exp) begin
      be_errs++;
      $display("Error %s byte select: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic problem(input string msg);
    other_errs++;
    $display("%s", msg);
  endtask

  // slave sees the bus mid cycle, answers a little after the next edge
  always begin
    @(negedge clk);
    ack_nxt = 1'b0;
    dat_nxt = wb_dat;
    if (!rst && wb_cyc && wb_stb && wb_ack) begin  // beat taken at the coming edge
      bus_adr.push_back(wb_adr);
      bus_we.push_back(wb_we);
      bus_sel.push_back(wb_sel);
    end else if (!rst && wb_cyc && wb_stb) begin
      if (wait_left != 0) begin
        wait_left--;
      end else begin
        cur = mem_read({wb_adr[31:2], 2'b00});
        if (wb_we) begin
          for (int b = 0; b < 4; b++)
            if (wb_sel[b]) cur[8*b +: 8] = wb_dat_m[8*b +: 8];
          shadow[{wb_adr[31:2], 2'b00}] = cur;
        end
        dat_nxt   = cur;
        ack_nxt   = 1'b1;
        rng       = xorshift(rng);
        wait_left = int'(rng % 4);  // 0 to 3 wait cycles
      end
    end
    @(posedge clk);
    #1;
    wb_ack = ack_nxt;
    wb_dat = dat_nxt;
  end

  task automatic run_access(input int n);
    string       name;
    logic [7:0]  op;
    addr_t       a;
    word_t       exp;
    logic [5:0]  idx;
    logic        hit;
    int          cycles;
    int          nw;
    addr_t       exp_adr;
    op   = pat[n*COLS][7:0];
    a    = pat[n*COLS+1];
    exp  = pat[n*COLS+5];
    name = $sformatf("pattern %0d", n);
    if (op == 8'd2) begin  // shadow memory check only
      check_word(name, exp, mem_read(a));
      return;
    end
    idx = a[11:6];
    hit = valid_m[idx] && tag_m[idx] == a[31:12];
    bus_adr.delete();
    bus_we.delete();
    bus_sel.delete();
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req_we    = op[0];
    req_addr  = a;
    req_wdata = pat[n*COLS+2];
    req_be    = be_t'(pat[n*COLS+3]);
    req_size  = size_t'(pat[n*COLS+4][1:0]);
    cycles    = 0;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end while (!ready && cycles < 200);
    if (!ready)
      problem($sformatf("%s: no ready within 200 cycles", name));
    else if (!op[0])
      check_word(name, exp, rdata);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    if (a[31]) begin
      if (bus_adr.size() != 1) begin
        problem($sformatf("%s: uncached access made %0d bus cycles", name, bus_adr.size()));
      end else begin
        check_addr(name, {a[31:2], 2'b00}, bus_adr[0]);
        if (bus_we[0] !== op[0])
          problem($sformatf("%s: uncached bus cycle has the wrong direction", name));
        if (op[0])
          check_be(name, req_be, bus_sel[0]);
      end
    end else if (hit) begin
      if (bus_adr.size() != 0)
        problem($sformatf("%s: hit made %0d bus cycles", name, bus_adr.size()));
      if (cycles != 2)
        problem($sformatf("%s: hit answered after %0d cycles, not 2", name, cycles));
    end else begin
      nw = dirty_m[idx] ? 16 : 0;
      if (bus_adr.size() != nw + 16) begin
        problem($sformatf("%s: miss made %0d bus cycles, expected %0d",
                          name, bus_adr.size(), nw + 16));
      end else begin
        for (int k = 0; k < nw + 16; k++) begin
          if (k < nw)
            exp_adr = {tag_m[idx], idx, 6'b0} + addr_t'(4*k);  // victim line
          else
            exp_adr = {a[31:6], 6'b0} + addr_t'(4*(k-nw));
          check_addr(name, exp_adr, bus_adr[k]);
          check_be(name, '1, bus_sel[k]);  // line beats move whole words
          if (bus_we[k] !== (k < nw))
            problem($sformatf("%s: beat %0d has the wrong direction", name, k));
        end
      end
      valid_m[idx] = 1'b1;
      tag_m[idx]   = a[31:12];
      dirty_m[idx] = 1'b0;
    end
    if (!a[31] && op[0])
      dirty_m[idx] = 1'b1;
  endtask

  initial begin
    rst       = 1'b1;
    req_valid = 1'b0;
    req_we    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_be    = '0;
    req_size  = SIZE_WORD;
    wb_ack    = 1'b0;
    wb_dat    = '0;
    for (int i = 0; i < 64; i++) begin
      valid_m[i] = 1'b0;
      dirty_m[i] = 1'b0;
      tag_m[i]   = '0;
    end
    $readmemh("sim/dcache_patterns.txt", pat);
    npat = 0;
    while (npat < MAX_PAT && (pat[npat*COLS] === 32'd0 || pat[npat*COLS] === 32'd1 ||
           pat[npat*COLS] === 32'd2))
      npat++;
    if (npat == 0)
      problem("no patterns read from sim/dcache_patterns.txt");
    started = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || ready !== 1'b0)
      problem("bus or ready active right after reset");
    for (int i = 0; i < npat; i++)
      run_access(i);
    other_errs += u_dut.u_ctrl.u_props.fail_cnt;  // failed bound assertions
    $display("errors: data %0d, address %0d, select %0d, other %0d",
             data_errs, addr_errs, be_errs, other_errs);
    if (data_errs + addr_errs + be_errs + other_errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // 200 cycles per access is far above a dirty miss with 3 wait cycles per beat
  initial begin
    wait (started);
    repeat (npat*200 + 40) @(posedge clk);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: sim/dcache_patterns.txt
// op addr wdata be size expected, all hex
// op 0 read, 1 write, 2 check bus memory word, ff ends the list
0 00001040 00000000 f 2 0410fbef
0 0000107c 00000000 f 2 041ffbe0
0 00001044 00000000 f 2 0411fbee
1 00001048 aabbccdd 5 2 00000000
0 00001048 00000000 f 2 04bbfbdd
1 0000104c 11223344 c 2 00000000
// same index, new tag, dirty victim goes out
0 00002048 00000000 f 2 0812f7ed
2 00001048 00000000 0 0 04bbfbdd
2 0000104c 00000000 0 0 1122fbec
2 00001040 00000000 0 0 0410fbef
0 00001048 00000000 f 2 04bbfbdd
0 0000104c 00000000 f 2 1122fbec
// uncached loads, zero extended
0 80000101 00000000 2 0 000000ff
0 80000102 00000000 4 0 00000040
0 80000200 00000000 3 1 0000ff7f
0 80000204 00000000 f 2 0081ff7e
1 80000208 deadbeef 3 2 00000000
2 80000208 00000000 0 0 0082beef
0 80000208 00000000 f 2 0082beef
0 00001048 00000000 f 2 04bbfbdd
// write miss, then victim of index 0
1 00003010 cafef00d f 2 00000000
0 00003010 00000000 f 2 cafef00d
0 00003014 00000000 f 2 0c05f3fa
0 00000004 00000000 f 2 0001fffe
2 00003010 00000000 0 0 cafef00d
0 00003010 00000000 f 2 cafef00d
ff 0 0 0 0 0

// File: compile.f
rtl/mem_access_pkg.sv
rtl/dcache_cfg_pkg.sv
rtl/data_bank.sv
rtl/tag_store.sv
rtl/load_align.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
sim/dcache_properties.sv
sim/tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dcache -f compile.f -o tb_dcache_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dcache_sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
